/* hdl/vec_cfg_pkg.sv */
////////////////////
// Vector configuration definitions
// Sizes, element width and LMUL encodings, vtype and CSR addresses
////////////////////

package vec_cfg_pkg;

  // Architecture sizes
  localparam int unsigned VLEN    = 256;
  localparam int unsigned VLENB   = VLEN / 8;
  localparam int unsigned ELEN    = 32;
  localparam int unsigned NR_VREG = 32;
  localparam int unsigned NR_INSN = 4;

  typedef logic [$clog2(VLEN):0]      vlen_t;
  typedef logic [$clog2(NR_VREG)-1:0] vreg_t;
  typedef logic [$clog2(NR_INSN)-1:0] insn_id_t;
  typedef logic [ELEN-1:0]            elen_t;

  typedef enum logic [2:0] {
    EW_8  = 3'd0,
    EW_16 = 3'd1,
    EW_32 = 3'd2,
    EW_64 = 3'd3
  } vew_e;

  // RVV encoding, fractional values read as negative log2
  typedef enum logic [2:0] {
    LMUL_1   = 3'd0,
    LMUL_2   = 3'd1,
    LMUL_4   = 3'd2,
    LMUL_8   = 3'd3,
    LMUL_RES = 3'd4,
    LMUL_F8  = 3'd5,
    LMUL_F4  = 3'd6,
    LMUL_F2  = 3'd7
  } vlmul_e;

  typedef struct packed {
    logic   vill;
    vlmul_e vlmul;
    vew_e   vsew;
  } vtype_t;

  // Value loaded on reset and by a rejected vsetvl
  localparam vtype_t VTYPE_ILL = '{vill: 1'b1, vlmul: LMUL_1, vsew: EW_8};

  typedef enum logic [11:0] {
    CSR_VSTART = 12'h008,
    CSR_VL     = 12'hC20,
    CSR_VTYPE  = 12'hC21,
    CSR_VLENB  = 12'hC22
  } csr_addr_e;

  typedef struct packed {
    vlen_t  vl;
    vlen_t  vstart;
    vtype_t vtype;
  } csr_state_t;

endpackage

/* hdl/vec_req_pkg.sv */
////////////////////
// Request and response types
// Structs exchanged with the core, the units and the scoreboard
////////////////////

package vec_req_pkg;

  import vec_cfg_pkg::*;

  typedef enum logic [3:0] {
    VSETVL  = 4'd0,
    CSR_RD  = 4'd1,
    CSR_WR  = 4'd2,
    CSR_SET = 4'd3,
    CSR_CLR = 4'd4,
    V_ARITH = 4'd5,
    V_LOAD  = 4'd6,
    V_STORE = 4'd7,
    V_SLIDE = 4'd8
  } op_e;

  // CON stays inside the controller, the others are execution units
  typedef enum logic [1:0] {
    CON = 2'd0,
    VFU = 2'd1,
    LSU = 2'd2,
    SLD = 2'd3
  } unit_e;

  localparam int unsigned NR_UNITS = 3;

  typedef struct packed {
    op_e       op;
    vreg_t     vd;
    vreg_t     vs1;
    vreg_t     vs2;
    logic      use_vd_src;
    elen_t     rs1;
    logic [4:0] rd;
    csr_addr_e csr_addr;
    vtype_t    vtype;
  } issue_req_t;

  typedef struct packed {
    logic accept;
    logic writeback;
    logic loadstore;
  } issue_resp_t;

  typedef struct packed {
    logic [4:0] rd;
    elen_t      data;
  } result_t;

  // Scalar operand and CSR address ride along for the CSR file
  typedef struct packed {
    op_e       op;
    unit_e     unit;
    insn_id_t  id;
    vreg_t     vd;
    vreg_t     vs1;
    vreg_t     vs2;
    logic      use_vs1;
    logic      use_vs2;
    logic      use_vd;
    logic      vd_is_src;
    vlen_t     vl;
    vlen_t     vstart;
    vtype_t    vtype;
    elen_t     rs1;
    csr_addr_e csr_addr;
  } unit_req_t;

  typedef struct packed {
    insn_id_t id;
  } unit_rsp_t;

  // Dispatched request, valid for one cycle
  typedef struct packed {
    logic      valid;
    unit_req_t req;
  } issue_strobe_t;

endpackage

/* hdl/vec_decoder.sv */
////////////////////
// Instruction decoder
// Sorts an issue request into a unit class and its register usage
////////////////////

module vec_decoder (
  input  vec_req_pkg::issue_req_t  issue_req_i,
  input  logic                     vill_i,
  output vec_req_pkg::unit_req_t   unit_req_o,
  output logic                     illegal_o,
  output vec_req_pkg::issue_resp_t resp_o
);

  import vec_req_pkg::*;

  logic is_vector;

  always_comb begin : proc_decode
    unit_req_o          = '0;
    unit_req_o.op       = issue_req_i.op;
    unit_req_o.vd       = issue_req_i.vd;
    unit_req_o.vs1      = issue_req_i.vs1;
    unit_req_o.vs2      = issue_req_i.vs2;
    unit_req_o.rs1      = issue_req_i.rs1;
    unit_req_o.csr_addr = issue_req_i.csr_addr;
    unit_req_o.vtype    = issue_req_i.vtype;
    illegal_o           = 1'b0;

    case (issue_req_i.op)
      VSETVL, CSR_RD, CSR_WR, CSR_SET, CSR_CLR: unit_req_o.unit = CON;
      V_ARITH: begin
        unit_req_o.unit      = VFU;
        unit_req_o.use_vs1   = 1'b1;
        unit_req_o.use_vs2   = 1'b1;
        unit_req_o.use_vd    = 1'b1;
        unit_req_o.vd_is_src = issue_req_i.use_vd_src;
      end
      V_LOAD: begin
        unit_req_o.unit      = LSU;
        unit_req_o.use_vd    = 1'b1;
        unit_req_o.vd_is_src = issue_req_i.use_vd_src;
      end
      V_STORE: begin
        // Store data comes out of vd
        unit_req_o.unit      = LSU;
        unit_req_o.vd_is_src = 1'b1;
      end
      V_SLIDE: begin
        unit_req_o.unit      = SLD;
        unit_req_o.use_vs2   = 1'b1;
        unit_req_o.use_vd    = 1'b1;
        unit_req_o.vd_is_src = issue_req_i.use_vd_src;
      end
      default: illegal_o = 1'b1;
    endcase
  end

  assign is_vector = !illegal_o && (unit_req_o.unit != CON);

  // Vector work needs a legal vtype
  always_comb begin : proc_resp
    resp_o.accept    = !illegal_o && !(is_vector && vill_i);
    resp_o.writeback = !illegal_o && (unit_req_o.unit == CON);
    resp_o.loadstore = issue_req_i.op inside {V_LOAD, V_STORE};
  end

endmodule

/* hdl/vec_csr_file.sv */
////////////////////
// Vector CSR file
// vstart, vl and vtype with vsetvl and CSR access
////////////////////

module vec_csr_file (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  vec_req_pkg::issue_strobe_t strobe_i,
  output vec_cfg_pkg::csr_state_t    csr_o,
  output vec_cfg_pkg::elen_t         result_o
);

  import vec_cfg_pkg::*;
  import vec_req_pkg::*;

  csr_state_t csr_q, csr_d;
  unit_req_t  req;
  logic       vtype_bad;
  vlen_t      vl_new;
  elen_t      rd_data;

  // Request fields are valid whenever the buffer holds one
  assign req = strobe_i.req;

  ////////////////////
  // vsetvl

  always_comb begin : proc_vsetvl
    int lmul_log;
    int vlmax;
    lmul_log  = int'($signed(req.vtype.vlmul));
    // ELEN x LMUL must still hold one element
    vtype_bad = (req.vtype.vsew > EW_32) ||
                (req.vtype.vlmul inside {LMUL_RES, LMUL_F8}) ||
                (lmul_log + $clog2(ELEN) < int'(req.vtype.vsew) + 3);

    vlmax = VLENB >> req.vtype.vsew;
    if (lmul_log < 0) begin
      vlmax = vlmax >> (-lmul_log);
    end else begin
      vlmax = vlmax << lmul_log;
    end

    // All ones in rs1 also lands on vlmax
    if (vtype_bad) begin
      vl_new = '0;
    end else if (req.rs1 == '1 || req.rs1 > elen_t'(vlmax)) begin
      vl_new = vlen_t'(vlmax);
    end else begin
      vl_new = vlen_t'(req.rs1);
    end
  end

  ////////////////////
  // State update

  always_comb begin : proc_update
    csr_d = csr_q;
    if (strobe_i.valid) begin
      case (req.op)
        VSETVL: begin
          csr_d.vl = vl_new;
          if (vtype_bad) begin
            csr_d.vtype = VTYPE_ILL;
          end else begin
            csr_d.vtype      = req.vtype;
            csr_d.vtype.vill = 1'b0;
          end
        end
        CSR_WR, CSR_SET, CSR_CLR: begin
          // Only vstart is writable
          if (req.csr_addr == CSR_VSTART) begin
            case (req.op)
              CSR_WR:  csr_d.vstart = vlen_t'(req.rs1);
              CSR_SET: csr_d.vstart = csr_q.vstart | vlen_t'(req.rs1);
              default: csr_d.vstart = csr_q.vstart & ~vlen_t'(req.rs1);
            endcase
          end
        end
        CSR_RD: ;
        default: csr_d.vstart = '0;
      endcase
    end
  end

  // CSR ops return the value before the update
  always_comb begin : proc_read
    case (req.csr_addr)
      CSR_VSTART: rd_data = elen_t'(csr_q.vstart);
      CSR_VL:     rd_data = elen_t'(csr_q.vl);
      CSR_VTYPE:  rd_data = {csr_q.vtype.vill, {(ELEN - 7){1'b0}},
                             csr_q.vtype.vsew, csr_q.vtype.vlmul};
      CSR_VLENB:  rd_data = elen_t'(VLENB);
      default:    rd_data = '0;
    endcase
  end

  assign result_o = (req.op == VSETVL) ? elen_t'(vl_new) : rd_data;
  assign csr_o    = csr_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      csr_q <= '{vl: '0, vstart: '0, vtype: VTYPE_ILL};
    end else begin
      csr_q <= csr_d;
    end
  end

endmodule

/* hdl/vec_scoreboard.sv */
////////////////////
// Register scoreboard
// Tracks vector register hazards and gates port enables
////////////////////

module vec_scoreboard (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  vec_req_pkg::issue_strobe_t                        strobe_i,
  input  logic                  [vec_req_pkg::NR_UNITS-1:0] unit_rsp_valid_i,
  input  vec_req_pkg::unit_rsp_t [vec_req_pkg::NR_UNITS-1:0] unit_rsp_i,
  input  logic                  [vec_req_pkg::NR_UNITS-1:0] sb_enable_i,
  input  vec_cfg_pkg::insn_id_t [vec_req_pkg::NR_UNITS-1:0] sb_id_i,
  input  logic                  [vec_req_pkg::NR_UNITS-1:0] sb_wrote_i,
  output logic                  [vec_req_pkg::NR_UNITS-1:0] sb_enable_o
);

  import vec_cfg_pkg::*;
  import vec_req_pkg::*;

  typedef struct packed {
    logic     valid;
    insn_id_t id;
  } owner_t;

  // Last reader and writer of each register
  owner_t [NR_VREG-1:0] rd_tab_q, rd_tab_d;
  owner_t [NR_VREG-1:0] wr_tab_q, wr_tab_d;
  // Row i holds the instructions that i waits for
  logic [NR_INSN-1:0][NR_INSN-1:0] deps_q, deps_d;
  logic [NR_INSN-1:0]              wrote_q, wrote_d;
  unit_req_t                       req;

  assign req = strobe_i.req;

  ////////////////////
  // Port gating

  always_comb begin : proc_enable
    for (int p = 0; p < NR_UNITS; p++) begin
      sb_enable_o[p] = sb_enable_i[p] && (&(~deps_q[sb_id_i[p]] | wrote_q));
    end
  end

  always_comb begin : proc_wrote
    wrote_d = '0;
    for (int p = 0; p < NR_UNITS; p++) begin
      if (sb_enable_o[p]) begin
        wrote_d[sb_id_i[p]] = wrote_d[sb_id_i[p]] | sb_wrote_i[p];
      end
    end
  end

  ////////////////////
  // Tables

  always_comb begin : proc_tables
    vreg_t [2:0] src;
    logic  [2:0] src_en;
    rd_tab_d = rd_tab_q;
    wr_tab_d = wr_tab_q;
    deps_d   = deps_q;
    src      = {req.vd, req.vs1, req.vs2};
    src_en   = {req.vd_is_src, req.use_vs1, req.use_vs2};

    // Finished instructions leave the tables
    for (int u = 0; u < NR_UNITS; u++) begin
      if (unit_rsp_valid_i[u]) begin
        for (int r = 0; r < NR_VREG; r++) begin
          if (rd_tab_q[r].valid && rd_tab_q[r].id == unit_rsp_i[u].id) begin
            rd_tab_d[r].valid = 1'b0;
          end
          if (wr_tab_q[r].valid && wr_tab_q[r].id == unit_rsp_i[u].id) begin
            wr_tab_d[r].valid = 1'b0;
          end
        end
        deps_d[unit_rsp_i[u].id] = '0;
        for (int i = 0; i < NR_INSN; i++) begin
          deps_d[i][unit_rsp_i[u].id] = 1'b0;
        end
      end
    end

    if (strobe_i.valid && req.unit != CON) begin
      // RAW on every source
      for (int s = 0; s < 3; s++) begin
        if (src_en[s] && wr_tab_d[src[s]].valid) begin
          deps_d[req.id][wr_tab_d[src[s]].id] = 1'b1;
        end
      end
      // WAW and WAR on the destination
      if (req.use_vd) begin
        if (wr_tab_d[req.vd].valid) begin
          deps_d[req.id][wr_tab_d[req.vd].id] = 1'b1;
        end
        if (rd_tab_d[req.vd].valid) begin
          deps_d[req.id][rd_tab_d[req.vd].id] = 1'b1;
        end
      end
      // Record ownership once all hazards are taken
      for (int s = 0; s < 3; s++) begin
        if (src_en[s]) begin
          rd_tab_d[src[s]] = '{valid: 1'b1, id: req.id};
        end
      end
      if (req.use_vd) begin
        wr_tab_d[req.vd] = '{valid: 1'b1, id: req.id};
      end
    end

    // No self dependency
    for (int i = 0; i < NR_INSN; i++) begin
      deps_d[i][i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_tab_q <= '0;
      wr_tab_q <= '0;
      deps_q   <= '0;
      wrote_q  <= '0;
    end else begin
      rd_tab_q <= rd_tab_d;
      wr_tab_q <= wr_tab_d;
      deps_q   <= deps_d;
      wrote_q  <= wrote_d;
    end
  end

endmodule

/* hdl/vec_issue.sv */
////////////////////
// Issue stage
// Request buffer, id allocation, dispatch and CSR write-back
////////////////////

module vec_issue (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  vec_req_pkg::unit_req_t                            dec_req_i,
  input  logic                                              dec_valid_i,
  output logic                                              issue_ready_o,
  input  vec_cfg_pkg::csr_state_t                           csr_i,
  input  vec_cfg_pkg::elen_t                                csr_result_i,
  input  logic                  [4:0]                       rd_i,
  input  logic                  [vec_req_pkg::NR_UNITS-1:0] unit_ready_i,
  input  logic                  [vec_req_pkg::NR_UNITS-1:0] unit_rsp_valid_i,
  input  vec_req_pkg::unit_rsp_t [vec_req_pkg::NR_UNITS-1:0] unit_rsp_i,
  output vec_req_pkg::issue_strobe_t                        strobe_o,
  output logic                  [vec_req_pkg::NR_UNITS-1:0] unit_req_valid_o,
  output vec_req_pkg::unit_req_t                            unit_req_o,
  output logic                                              result_valid_o,
  output vec_req_pkg::result_t                              result_o,
  input  logic                                              result_ready_i
);

  import vec_cfg_pkg::*;
  import vec_req_pkg::*;

  unit_req_t          buf_req_q;
  logic [4:0]         buf_rd_q;
  logic               buf_valid_q;
  logic [NR_INSN-1:0] running_q, running_d;
  logic [NR_UNITS-1:0] unit_sel;
  insn_id_t           next_id;
  logic               id_full;
  logic               is_con;
  logic               pop;
  unit_req_t          disp_req;

  assign is_con = (buf_req_q.unit == CON);

  // One-hot target unit, empty for CON
  always_comb begin : proc_unit_sel
    for (int u = 0; u < NR_UNITS; u++) begin
      unit_sel[u] = (buf_req_q.unit == unit_e'(u + 1));
    end
  end

  // Lowest free id wins
  always_comb begin : proc_next_id
    next_id = '0;
    for (int i = NR_INSN - 1; i >= 0; i--) begin
      if (!running_q[i]) begin
        next_id = insn_id_t'(i);
      end
    end
  end

  assign id_full = &running_q;

  // CON waits for the core, vector work for its unit and an id
  assign pop = buf_valid_q &&
               (is_con ? result_ready_i : (|(unit_sel & unit_ready_i) && !id_full));
  assign issue_ready_o = !buf_valid_q || pop;

  ////////////////////
  // Dispatch

  always_comb begin : proc_dispatch
    disp_req = buf_req_q;
    if (!is_con) begin
      disp_req.id     = next_id;
      disp_req.vl     = csr_i.vl;
      disp_req.vstart = csr_i.vstart;
      // Loads and stores keep their own element width
      if (buf_req_q.unit != LSU) begin
        disp_req.vtype = csr_i.vtype;
      end
    end
  end

  always_comb begin : proc_running
    running_d = running_q;
    if (pop && !is_con) begin
      running_d[next_id] = 1'b1;
    end
    for (int u = 0; u < NR_UNITS; u++) begin
      if (unit_rsp_valid_i[u]) begin
        running_d[unit_rsp_i[u].id] = 1'b0;
      end
    end
  end

  assign strobe_o         = '{valid: pop, req: disp_req};
  assign unit_req_o       = disp_req;
  assign unit_req_valid_o = pop ? unit_sel : '0;
  assign result_valid_o   = buf_valid_q && is_con;
  assign result_o         = '{rd: buf_rd_q, data: csr_result_i};

  always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
      buf_req_q <= dec_req_i;
      buf_rd_q  <= rd_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      buf_valid_q <= 1'b0;
      running_q   <= '0;
    end else begin
      buf_valid_q <= dec_valid_i || (buf_valid_q && !pop);
      running_q   <= running_d;
    end
  end

endmodule

/* hdl/vec_controller.sv */
////////////////////
// Vector issue controller
////////////////////

module vec_controller (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  // Issue from the core
  input  logic                                              issue_valid_i,
  input  vec_req_pkg::issue_req_t                           issue_req_i,
  output logic                                              issue_ready_o,
  output vec_req_pkg::issue_resp_t                          issue_resp_o,
  // Execution units
  output logic                  [vec_req_pkg::NR_UNITS-1:0] unit_req_valid_o,
  output vec_req_pkg::unit_req_t                            unit_req_o,
  input  logic                  [vec_req_pkg::NR_UNITS-1:0] unit_ready_i,
  input  logic                  [vec_req_pkg::NR_UNITS-1:0] unit_rsp_valid_i,
  input  vec_req_pkg::unit_rsp_t [vec_req_pkg::NR_UNITS-1:0] unit_rsp_i,
  // Register file ports
  input  logic                  [vec_req_pkg::NR_UNITS-1:0] sb_enable_i,
  input  vec_cfg_pkg::insn_id_t [vec_req_pkg::NR_UNITS-1:0] sb_id_i,
  input  logic                  [vec_req_pkg::NR_UNITS-1:0] sb_wrote_i,
  output logic                  [vec_req_pkg::NR_UNITS-1:0] sb_enable_o,
  // Write-back to the core
  output logic                                              result_valid_o,
  output vec_req_pkg::result_t                              result_o,
  input  logic                                              result_ready_i
);

  import vec_cfg_pkg::*;
  import vec_req_pkg::*;

  unit_req_t     dec_req;
  logic          dec_illegal;
  logic          dec_valid;
  csr_state_t    csr_state;
  elen_t         csr_result;
  issue_strobe_t issue_strobe;

  // Only accepted transfers enter the buffer
  assign dec_valid = issue_valid_i && issue_ready_o && issue_resp_o.accept && !dec_illegal;

  vec_decoder u_decoder (
    .issue_req_i (issue_req_i),
    .vill_i      (csr_state.vtype.vill),
    .unit_req_o  (dec_req),
    .illegal_o   (dec_illegal),
    .resp_o      (issue_resp_o)
  );

  vec_csr_file u_csr_file (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .strobe_i (issue_strobe),
    .csr_o    (csr_state),
    .result_o (csr_result)
  );

  vec_issue u_issue (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .dec_req_i        (dec_req),
    .dec_valid_i      (dec_valid),
    .issue_ready_o    (issue_ready_o),
    .csr_i            (csr_state),
    .csr_result_i     (csr_result),
    .rd_i             (issue_req_i.rd),
    .unit_ready_i     (unit_ready_i),
    .unit_rsp_valid_i (unit_rsp_valid_i),
    .unit_rsp_i       (unit_rsp_i),
    .strobe_o         (issue_strobe),
    .unit_req_valid_o (unit_req_valid_o),
    .unit_req_o       (unit_req_o),
    .result_valid_o   (result_valid_o),
    .result_o         (result_o),
    .result_ready_i   (result_ready_i)
  );

  vec_scoreboard u_scoreboard (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .strobe_i         (issue_strobe),
    .unit_rsp_valid_i (unit_rsp_valid_i),
    .unit_rsp_i       (unit_rsp_i),
    .sb_enable_i      (sb_enable_i),
    .sb_id_i          (sb_id_i),
    .sb_wrote_i       (sb_wrote_i),
    .sb_enable_o      (sb_enable_o)
  );

endmodule

/* verif/vec_controller_tb.sv */
////////////////////
// Vector controller testbench
// Table-driven issue, CSR, dispatch and scoreboard checks
////////////////////

module vec_controller_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import vec_cfg_pkg::*;
  import vec_req_pkg::*;

  localparam int TIMEOUT = 100;
  localparam logic [1:0] K_NONE   = 2'd0;
  localparam logic [1:0] K_RESULT = 2'd1;
  localparam logic [1:0] K_UNIT   = 2'd2;

  // One stimulus line with its expected outcome
  typedef struct packed {
    issue_req_t  req;
    logic        gap;
    logic        rsp_en;
    logic [1:0]  rsp_unit;
    insn_id_t    rsp_id;
    logic [2:0]  hold;
    issue_resp_t exp_resp;
    logic [1:0]  kind;
    elen_t       exp_data;
    unit_req_t   exp_ureq;
  } entry_t;

  logic                  clk_i;
  logic                  rst_i;
  logic                  issue_valid_i;
  issue_req_t            issue_req_i;
  logic                  issue_ready_o;
  issue_resp_t           issue_resp_o;
  logic [NR_UNITS-1:0]   unit_req_valid_o;
  unit_req_t             unit_req_o;
  logic [NR_UNITS-1:0]   unit_ready_i;
  logic [NR_UNITS-1:0]   unit_rsp_valid_i;
  unit_rsp_t [NR_UNITS-1:0] unit_rsp_i;
  logic [NR_UNITS-1:0]   sb_enable_i;
  insn_id_t [NR_UNITS-1:0] sb_id_i;
  logic [NR_UNITS-1:0]   sb_wrote_i;
  logic [NR_UNITS-1:0]   sb_enable_o;
  logic                  result_valid_o;
  result_t               result_o;
  logic                  result_ready_i;

  entry_t table_q[$];
  int     test_errors;
  int     n_pass;
  int     n_fail;
  int     seed = 4;

  vec_controller dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic vtype_t vt(vlmul_e m, vew_e e);
    return '{vill: 1'b0, vlmul: m, vsew: e};
  endfunction

  // One valid bit per unit, in the order VFU, LSU, SLD
  function automatic logic [NR_UNITS-1:0] unit_valid_bits(unit_e unit);
    case (unit)
      VFU:     return 3'b001;
      LSU:     return 3'b010;
      SLD:     return 3'b100;
      default: return '0;
    endcase
  endfunction

  function automatic void csr_entry(op_e op, csr_addr_e addr, vtype_t vtype, elen_t rs1,
                                    elen_t data, int hold);
    entry_t e;
    e              = '0;
    e.req.op       = op;
    e.req.csr_addr = addr;
    e.req.vtype    = vtype;
    e.req.rs1      = rs1;
    e.req.rd       = 5'(table_q.size() + 1);
    e.exp_resp     = '{accept: 1'b1, writeback: 1'b1, loadstore: 1'b0};
    e.kind         = K_RESULT;
    e.exp_data     = data;
    e.hold         = 3'(hold);
    table_q.push_back(e);
  endfunction

  function automatic void vector_entry(op_e op, vreg_t vd, vreg_t vs1, vreg_t vs2,
                                       vtype_t vtype, logic acc, unit_e unit, insn_id_t id,
                                       vlen_t vl, vlen_t vstart, vtype_t exp_vtype,
                                       logic gap, logic rsp_en, logic [1:0] rsp_unit,
                                       insn_id_t rsp_id);
    entry_t e;
    e                   = '0;
    e.req.op            = op;
    e.req.vd            = vd;
    e.req.vs1           = vs1;
    e.req.vs2           = vs2;
    e.req.vtype         = vtype;
    e.exp_resp          = '{accept: acc, writeback: 1'b0,
                            loadstore: (op == V_LOAD || op == V_STORE)};
    e.kind              = acc ? K_UNIT : K_NONE;
    e.gap               = gap;
    e.rsp_en            = rsp_en;
    e.rsp_unit          = rsp_unit;
    e.rsp_id            = rsp_id;
    e.exp_ureq.op       = op;
    e.exp_ureq.unit     = unit;
    e.exp_ureq.id       = id;
    e.exp_ureq.vd       = vd;
    e.exp_ureq.vs1      = vs1;
    e.exp_ureq.vs2      = vs2;
    e.exp_ureq.vl       = vl;
    e.exp_ureq.vstart   = vstart;
    e.exp_ureq.vtype    = exp_vtype;
    // Registers each kind of instruction reads or writes
    case (op)
      V_ARITH: begin
        e.exp_ureq.use_vs1 = 1'b1;
        e.exp_ureq.use_vs2 = 1'b1;
        e.exp_ureq.use_vd  = 1'b1;
      end
      V_LOAD:  e.exp_ureq.use_vd = 1'b1;
      V_STORE: e.exp_ureq.vd_is_src = 1'b1;
      V_SLIDE: begin
        e.exp_ureq.use_vs2 = 1'b1;
        e.exp_ureq.use_vd  = 1'b1;
      end
      default: ;
    endcase
    table_q.push_back(e);
  endfunction

  ////////////////////
  // Compare tasks

  task automatic check_resp(issue_resp_t exp, issue_resp_t act);
    if (act !== exp) begin
      $display("Error: issue_resp_o expected %h, got %h", exp, act);
      test_errors++;
    end
  endtask

  task automatic check_result(result_t exp, result_t act);
    if (act !== exp) begin
      $display("Error: result_o expected %h, got %h", exp, act);
      test_errors++;
    end
  endtask

  task automatic check_unit_req(unit_req_t exp, unit_req_t act);
    if (act !== exp) begin
      $display("Error: unit_req_o expected %h, got %h", exp, act);
      test_errors++;
    end
  endtask

  task automatic check_enable(string name, logic [NR_UNITS-1:0] exp,
                              logic [NR_UNITS-1:0] act);
    if (act !== exp) begin
      $display("Error: %s expected %h, got %h", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("Error: %s expected %h, got %h", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic abort_run(string what);
    $display("Timeout: %s", what);
    $display("TEST FAIL");
    $finish;
  endtask

  task automatic report_test(int idx);
    if (test_errors == 0) begin
      n_pass++;
      $display("Test %0d ok", idx);
    end else begin
      n_fail++;
      $display("Test %0d failed with %0d errors", idx, test_errors);
    end
  endtask

  task automatic send_rsp(int unit, insn_id_t id);
    @(negedge clk_i);
    unit_rsp_valid_i       = '0;
    unit_rsp_valid_i[unit] = 1'b1;
    unit_rsp_i[unit].id    = id;
    @(negedge clk_i);
    unit_rsp_valid_i = '0;
  endtask

  ////////////////////
  // Table entry

  task automatic apply_entry(int idx, entry_t e);
    int n;
    int gap;
    test_errors = 0;
    gap         = 0;
    @(negedge clk_i);
    if (e.hold != 0) result_ready_i = 1'b0;
    if (e.gap) begin
      gap          = 1 + ($random(seed) & 3);
      unit_ready_i = '0;
    end
    issue_valid_i = 1'b1;
    issue_req_i   = e.req;
    #1;
    n = 0;
    while (!issue_ready_o) begin
      n++;
      if (n > TIMEOUT) abort_run("issue handshake never completed");
      @(negedge clk_i);
      #1;
    end
    check_resp(e.exp_resp, issue_resp_o);
    @(negedge clk_i);
    issue_valid_i = 1'b0;
    if (e.kind == K_RESULT) begin
      // Core holds off the write-back
      for (int i = 0; i < int'(e.hold); i++) begin
        #1;
        check_flag("result_valid_o", 1'b1, result_valid_o);
        check_flag("issue_ready_o", 1'b0, issue_ready_o);
        @(negedge clk_i);
      end
      result_ready_i = 1'b1;
      #1;
      n = 0;
      while (!result_valid_o) begin
        n++;
        if (n > TIMEOUT) abort_run("no result from the controller");
        @(negedge clk_i);
        #1;
      end
      check_result('{rd: e.req.rd, data: e.exp_data}, result_o);
    end else if (e.kind == K_UNIT) begin
      for (int i = 0; i < gap; i++) begin
        #1;
        check_enable("unit_req_valid_o", '0, unit_req_valid_o);
        @(negedge clk_i);
      end
      unit_ready_i = '1;
      if (e.rsp_en) begin
        // All ids busy until a unit answers
        for (int i = 0; i < 3; i++) begin
          #1;
          check_enable("unit_req_valid_o", '0, unit_req_valid_o);
          @(negedge clk_i);
        end
        unit_rsp_valid_i[e.rsp_unit] = 1'b1;
        unit_rsp_i[e.rsp_unit].id    = e.rsp_id;
        #1;
        check_enable("unit_req_valid_o", '0, unit_req_valid_o);
        @(negedge clk_i);
        unit_rsp_valid_i = '0;
      end
      #1;
      n = 0;
      while (unit_req_valid_o == '0) begin
        n++;
        if (n > TIMEOUT) abort_run("vector request never dispatched");
        @(negedge clk_i);
        #1;
      end
      check_enable("unit_req_valid_o", unit_valid_bits(e.exp_ureq.unit), unit_req_valid_o);
      check_unit_req(e.exp_ureq, unit_req_o);
    end else begin
      #1;
      check_flag("result_valid_o", 1'b0, result_valid_o);
      check_enable("unit_req_valid_o", '0, unit_req_valid_o);
    end
    report_test(idx);
  endtask

  ////////////////////
  // Scoreboard

  // Port 2 carries B (id 1), port 0 carries A (id 0)
  task automatic scoreboard_test(int idx);
    test_errors = 0;
    @(negedge clk_i);
    sb_enable_i[2] = 1'b1;
    sb_id_i[2]     = 1;
    #1 check_enable("sb_enable_o", 3'b000, sb_enable_o);
    @(negedge clk_i);
    #1 check_enable("sb_enable_o", 3'b000, sb_enable_o);
    @(negedge clk_i);
    sb_enable_i[0] = 1'b1;
    sb_id_i[0]     = 0;
    sb_wrote_i[0]  = 1'b1;
    #1 check_enable("sb_enable_o", 3'b001, sb_enable_o);
    @(negedge clk_i);
    sb_enable_i[0] = 1'b0;
    sb_wrote_i[0]  = 1'b0;
    #1 check_enable("sb_enable_o", 3'b100, sb_enable_o);
    @(negedge clk_i);
    #1 check_enable("sb_enable_o", 3'b000, sb_enable_o);
    @(negedge clk_i);
    unit_rsp_valid_i[0] = 1'b1;
    unit_rsp_i[0].id    = 0;
    #1 check_enable("sb_enable_o", 3'b000, sb_enable_o);
    @(negedge clk_i);
    unit_rsp_valid_i = '0;
    #1 check_enable("sb_enable_o", 3'b100, sb_enable_o);
    @(negedge clk_i);
    sb_enable_i = '0;
    send_rsp(2, 1);
    report_test(idx);
  endtask

  initial begin
    rst_i            = 1'b1;
    issue_valid_i    = 1'b0;
    issue_req_i      = '0;
    unit_ready_i     = '1;
    unit_rsp_valid_i = '0;
    unit_rsp_i       = '0;
    sb_enable_i      = '0;
    sb_id_i          = '0;
    sb_wrote_i       = '0;
    result_ready_i   = 1'b1;
    n_pass           = 0;
    n_fail           = 0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    vector_entry(V_ARITH, 1, 2, 3, '0, 0, VFU, 0, 0, 0, '0, 0, 0, 0, 0);
    csr_entry(CSR_RD, CSR_VTYPE, '0, 0, 32'h8000_0000, 0);
    // vsetvl lengths
    csr_entry(VSETVL, CSR_VL, vt(LMUL_1, EW_32), '1, 8, 0);
    csr_entry(CSR_RD, CSR_VL, '0, 0, 8, 0);
    csr_entry(VSETVL, CSR_VL, vt(LMUL_2, EW_8), 5, 5, 0);
    csr_entry(CSR_RD, CSR_VL, '0, 0, 5, 0);
    csr_entry(VSETVL, CSR_VL, vt(LMUL_F2, EW_16), 100, 8, 0);
    csr_entry(VSETVL, CSR_VL, vt(LMUL_F4, EW_32), 3, 0, 0);
    csr_entry(CSR_RD, CSR_VTYPE, '0, 0, 32'h8000_0000, 0);
    csr_entry(VSETVL, CSR_VL, vt(LMUL_8, EW_8), '1, 256, 0);
    csr_entry(CSR_RD, CSR_VL, '0, 0, 256, 0);
    csr_entry(VSETVL, CSR_VL, vt(LMUL_1, EW_32), 7, 7, 0);
    // vstart access returns the old value
    csr_entry(CSR_WR, CSR_VSTART, '0, 12, 0, 0);
    csr_entry(CSR_SET, CSR_VSTART, '0, 3, 12, 0);
    csr_entry(CSR_CLR, CSR_VSTART, '0, 4, 15, 0);
    csr_entry(CSR_RD, CSR_VSTART, '0, 0, 11, 3);
    vector_entry(V_ARITH, 1, 2, 3, '0, 1, VFU, 0, 7, 11, vt(LMUL_1, EW_32), 0, 0, 0, 0);
    csr_entry(CSR_RD, CSR_VSTART, '0, 0, 0, 0);
    vector_entry(V_LOAD, 4, 0, 0, vt(LMUL_2, EW_8), 1, LSU, 1, 7, 0, vt(LMUL_2, EW_8),
                 1, 0, 0, 0);
    vector_entry(V_SLIDE, 5, 0, 6, '0, 1, SLD, 2, 7, 0, vt(LMUL_1, EW_32), 0, 0, 0, 0);
    vector_entry(V_STORE, 7, 0, 0, vt(LMUL_1, EW_16), 1, LSU, 3, 7, 0, vt(LMUL_1, EW_16),
                 0, 0, 0, 0);
    vector_entry(V_ARITH, 8, 9, 9, '0, 1, VFU, 1, 7, 0, vt(LMUL_1, EW_32), 0, 1, 1, 1);

    for (int i = 0; i < table_q.size(); i++) begin
      apply_entry(i, table_q[i]);
    end

    // Drain every running id before the hazard case
    send_rsp(0, 0);
    send_rsp(0, 1);
    send_rsp(2, 2);
    send_rsp(1, 3);
    vector_entry(V_ARITH, 10, 11, 12, '0, 1, VFU, 0, 7, 0, vt(LMUL_1, EW_32), 0, 0, 0, 0);
    vector_entry(V_SLIDE, 13, 0, 10, '0, 1, SLD, 1, 7, 0, vt(LMUL_1, EW_32), 0, 0, 0, 0);
    apply_entry(table_q.size() - 2, table_q[table_q.size() - 2]);
    apply_entry(table_q.size() - 1, table_q[table_q.size() - 1]);
    scoreboard_test(table_q.size());

    $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
hdl/vec_cfg_pkg.sv
hdl/vec_req_pkg.sv
hdl/vec_decoder.sv
hdl/vec_csr_file.sv
hdl/vec_scoreboard.sv
hdl/vec_issue.sv
hdl/vec_controller.sv
verif/vec_controller_tb.sv

/* Makefile */
# Verilator build and run for the vector controller testbench

VERILATOR ?= verilator
TOP       ?= vec_controller_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
